//--- verilog/error_tracker_pkg.sv
package error_tracker_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int LANES  = 16;                  // Receiver lanes.
    localparam int ERR_W  = 8;                   // Signed error estimate per lane.
    localparam int FLAG_W = 3;                   // Slicer decision flags per lane.
    localparam int WINDOW = 3;                   // Cycles kept per capture.
    localparam int ADDR_W = 4;                   // Capture memory address.
    localparam int DEPTH  = 1 << ADDR_W;         // Capture entries.
    localparam int CNT_W  = $clog2(LANES + 1);   // Holds 0 to LANES.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Vector types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One bit per lane, used for PRBS error flags and sliced bits.
    typedef logic [LANES-1:0] lane_vec_t;

    // Lane n sits in bits [n*ERR_W +: ERR_W], two's complement.
    typedef logic [LANES*ERR_W-1:0] err_vec_t;

    // Lane n sits in bits [n*FLAG_W +: FLAG_W].
    typedef logic [LANES*FLAG_W-1:0] flag_vec_t;

    typedef logic [CNT_W-1:0] lane_cnt_t;        // Flagged lane count.

    typedef logic [ADDR_W-1:0] cap_addr_t;       // Capture entry index.

    // Window slot, 0 is the oldest cycle and 2 the trigger cycle.
    // Slot 3 reads back as zero.
    typedef logic [1:0] slot_t;

    // Trigger fires when the flagged lane count is above this value.
    typedef logic [1:0] mode_t;

endpackage : error_tracker_pkg

//--- verilog/trigger_detector.sv
`timescale 1ns/1ps

module trigger_detector import error_tracker_pkg::*; (
    input  logic      clk,
    input  logic      rstb,
    input  lane_vec_t prbs_flags_i,
    input  mode_t     mode_i,
    output logic      trig_o,
    output lane_cnt_t trig_count_o
);

    lane_cnt_t ones;                             // Flagged lanes this cycle.
    logic      hit;                              // Count above threshold.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Population count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        ones = '0;
        for (int i = 0; i < LANES; i++) begin
            ones = ones + lane_cnt_t'(prbs_flags_i[i]);
        end
    end

    // Mode 0 fires on a single lane, mode 3 needs four or more.
    assign hit = (ones > lane_cnt_t'(mode_i));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Registered on the same edge the history takes the lane words,
    // so trig_o lines up with window slot 2.
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            trig_o       <= 1'b0;
            trig_count_o <= '0;
        end else begin
            trig_o       <= hit;
            trig_count_o <= ones;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_count_range : assert property (
        @(posedge clk) disable iff (!rstb)
        trig_count_o <= lane_cnt_t'(LANES)
    ) else $error("trigger count above lane number");

endmodule : trigger_detector

//--- verilog/sample_history.sv
`timescale 1ns/1ps

module sample_history import error_tracker_pkg::*; (
    input  logic      clk,
    input  logic      rstb,
    input  lane_vec_t sliced_bits_i,
    input  err_vec_t  est_error_i,
    input  flag_vec_t sd_flags_i,
    output lane_vec_t win_bits_o  [WINDOW],
    output err_vec_t  win_err_o   [WINDOW],
    output flag_vec_t win_flags_o [WINDOW]
);

    // The window registers are the delay line itself.
    // Slot WINDOW-1 takes the new word, older words move toward slot 0.
    // After edge k the window holds cycles k-2, k-1 and k.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sliced bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            for (int s = 0; s < WINDOW; s++) begin
                win_bits_o[s] <= '0;
            end
        end else begin
            for (int s = 0; s < WINDOW - 1; s++) begin
                win_bits_o[s] <= win_bits_o[s+1];    // Age by one cycle.
            end
            win_bits_o[WINDOW-1] <= sliced_bits_i;   // Newest cycle.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Error estimates
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            for (int s = 0; s < WINDOW; s++) begin
                win_err_o[s] <= '0;
            end
        end else begin
            for (int s = 0; s < WINDOW - 1; s++) begin
                win_err_o[s] <= win_err_o[s+1];
            end
            win_err_o[WINDOW-1] <= est_error_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Slicer flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            for (int s = 0; s < WINDOW; s++) begin
                win_flags_o[s] <= '0;
            end
        end else begin
            for (int s = 0; s < WINDOW - 1; s++) begin
                win_flags_o[s] <= win_flags_o[s+1];
            end
            win_flags_o[WINDOW-1] <= sd_flags_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Oldest slot must be the newest word from two cycles back.
    a_window_age : assert property (
        @(posedge clk) disable iff (!rstb)
        ##2 (win_bits_o[0] == $past(sliced_bits_i, 3)) &&
            (win_err_o[0] == $past(est_error_i, 3))
    ) else $error("history window out of order");

endmodule : sample_history

//--- verilog/capture_memory.sv
`timescale 1ns/1ps

module capture_memory import error_tracker_pkg::*; (
    input  logic              clk,
    input  logic              rstb,
    input  logic              trig_i,
    input  lane_cnt_t         trig_count_i,
    input  lane_vec_t         win_bits_i  [WINDOW],
    input  err_vec_t          win_err_i   [WINDOW],
    input  flag_vec_t         win_flags_i [WINDOW],
    input  logic              clear_i,
    input  cap_addr_t         rd_addr_i,
    input  slot_t             rd_slot_i,
    output lane_vec_t         rd_bits_o,
    output err_vec_t          rd_err_o,
    output flag_vec_t         rd_flags_o,
    output lane_cnt_t         rd_count_o,
    output logic [ADDR_W:0]   capture_count_o,
    output logic              full_o
);

    // Capture storage, one entry per trigger.
    lane_vec_t mem_bits  [DEPTH][WINDOW];
    err_vec_t  mem_err   [DEPTH][WINDOW];
    flag_vec_t mem_flags [DEPTH][WINDOW];
    lane_cnt_t mem_count [DEPTH];

    cap_addr_t wr_ptr;                           // Next entry to fill.
    logic      wr_en;
    logic      rd_valid;                         // Addressed entry holds a capture.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign full_o = (capture_count_o == (ADDR_W+1)'(DEPTH));
    assign wr_en  = trig_i && !full_o && !clear_i;   // Clear wins over a trigger.

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            wr_ptr          <= '0;
            capture_count_o <= '0;
        end else if (clear_i) begin
            wr_ptr          <= '0;
            capture_count_o <= '0;
        end else if (wr_en) begin
            wr_ptr          <= wr_ptr + 1'b1;        // Wraps once full.
            capture_count_o <= capture_count_o + {{ADDR_W{1'b0}}, 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int s = 0; s < WINDOW; s++) begin
                mem_bits[wr_ptr][s]  <= win_bits_i[s];
                mem_err[wr_ptr][s]   <= win_err_i[s];
                mem_flags[wr_ptr][s] <= win_flags_i[s];
            end
            mem_count[wr_ptr] <= trig_count_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Entries past the fill level read as zero.
    assign rd_valid = ({1'b0, rd_addr_i} < capture_count_o);

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            rd_bits_o  <= '0;
            rd_err_o   <= '0;
            rd_flags_o <= '0;
            rd_count_o <= '0;
        end else begin
            rd_bits_o  <= '0;
            rd_err_o   <= '0;
            rd_flags_o <= '0;
            rd_count_o <= rd_valid ? mem_count[rd_addr_i] : '0;
            if (rd_valid && (rd_slot_i < slot_t'(WINDOW))) begin
                rd_bits_o  <= mem_bits[rd_addr_i][rd_slot_i];
                rd_err_o   <= mem_err[rd_addr_i][rd_slot_i];
                rd_flags_o <= mem_flags[rd_addr_i][rd_slot_i];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_fill_range : assert property (
        @(posedge clk) disable iff (!rstb)
        capture_count_o <= (ADDR_W+1)'(DEPTH)
    ) else $error("capture count above memory depth");

    // A full memory keeps its pointer and stays full until cleared.
    a_no_write_full : assert property (
        @(posedge clk) disable iff (!rstb)
        (full_o && !clear_i) |=> ($stable(wr_ptr) && full_o)
    ) else $error("write while capture memory full");

endmodule : capture_memory

//--- verilog/error_tracker.sv
`timescale 1ns/1ps

module error_tracker import error_tracker_pkg::*; (
    input  logic            clk,
    input  logic            rstb,
    input  lane_vec_t       prbs_flags_i,
    input  lane_vec_t       sliced_bits_i,
    input  err_vec_t        est_error_i,
    input  flag_vec_t       sd_flags_i,
    input  mode_t           mode_i,
    input  logic            clear_i,
    input  cap_addr_t       rd_addr_i,
    input  slot_t           rd_slot_i,
    output lane_vec_t       rd_bits_o,
    output err_vec_t        rd_err_o,
    output flag_vec_t       rd_flags_o,
    output lane_cnt_t       rd_count_o,
    output logic [ADDR_W:0] capture_count_o,
    output logic            full_o
);

    logic      trig;                             // Aligned with window slot 2.
    lane_cnt_t trig_count;
    lane_vec_t win_bits  [WINDOW];
    err_vec_t  win_err   [WINDOW];
    flag_vec_t win_flags [WINDOW];

    trigger_detector i_trigger_detector (
        .clk          (clk),
        .rstb         (rstb),
        .prbs_flags_i (prbs_flags_i),
        .mode_i       (mode_i),
        .trig_o       (trig),
        .trig_count_o (trig_count)
    );

    sample_history i_sample_history (
        .clk           (clk),
        .rstb          (rstb),
        .sliced_bits_i (sliced_bits_i),
        .est_error_i   (est_error_i),
        .sd_flags_i    (sd_flags_i),
        .win_bits_o    (win_bits),
        .win_err_o     (win_err),
        .win_flags_o   (win_flags)
    );

    capture_memory i_capture_memory (
        .clk             (clk),
        .rstb            (rstb),
        .trig_i          (trig),
        .trig_count_i    (trig_count),
        .win_bits_i      (win_bits),
        .win_err_i       (win_err),
        .win_flags_i     (win_flags),
        .clear_i         (clear_i),
        .rd_addr_i       (rd_addr_i),
        .rd_slot_i       (rd_slot_i),
        .rd_bits_o       (rd_bits_o),
        .rd_err_o        (rd_err_o),
        .rd_flags_o      (rd_flags_o),
        .rd_count_o      (rd_count_o),
        .capture_count_o (capture_count_o),
        .full_o          (full_o)
    );

endmodule : error_tracker

//--- dv/error_tracker_tb.sv
`timescale 1ns/1ps

module error_tracker_tb import error_tracker_pkg::*; ();

    localparam int RUN_CYCLES  = DEPTH - 4;      // Random cycles per mode.
    localparam int READ_CYCLES = DEPTH * 4;      // One full readback walk.
    localparam int PHASE_COST  = RUN_CYCLES + 2 * READ_CYCLES + 16;
    localparam int MAX_CYCLES  = 4 + 8 * PHASE_COST + 200;

    logic            clk;
    logic            rstb;
    lane_vec_t       prbs_flags_i;
    lane_vec_t       sliced_bits_i;
    err_vec_t        est_error_i;
    flag_vec_t       sd_flags_i;
    mode_t           mode_i;
    logic            clear_i;
    cap_addr_t       rd_addr_i;
    slot_t           rd_slot_i;
    lane_vec_t       rd_bits_o;
    err_vec_t        rd_err_o;
    flag_vec_t       rd_flags_o;
    lane_cnt_t       rd_count_o;
    logic [ADDR_W:0] capture_count_o;
    logic            full_o;

    // Model state, updated on the same edges as the DUT.
    lane_vec_t hist_bits  [WINDOW];
    err_vec_t  hist_err   [WINDOW];
    flag_vec_t hist_flags [WINDOW];
    lane_vec_t pend_bits  [WINDOW];
    err_vec_t  pend_err   [WINDOW];
    flag_vec_t pend_flags [WINDOW];
    logic      pend_trig;
    lane_cnt_t pend_count;
    lane_vec_t exp_bits  [DEPTH][WINDOW];
    err_vec_t  exp_err   [DEPTH][WINDOW];
    flag_vec_t exp_flags [DEPTH][WINDOW];
    lane_cnt_t exp_count [DEPTH];
    int        model_count;
    int        cycles;
    int        errors;

    error_tracker i_error_tracker (.*);

    always #20 clk = ~clk;                       // 40 ns period.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int count_flags(lane_vec_t flags);
        return $countones(flags);
    endfunction

    function automatic logic expected_trigger(lane_vec_t flags, mode_t mode);
        return count_flags(flags) > int'(mode);
    endfunction

    always @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            for (int s = 0; s < WINDOW; s++) begin
                hist_bits[s]  = '0;
                hist_err[s]   = '0;
                hist_flags[s] = '0;
            end
            pend_trig   = 1'b0;
            pend_count  = '0;
            model_count = 0;
        end else begin
            if (clear_i) begin
                model_count = 0;                 // Clear beats the write.
            end else if (pend_trig && model_count < DEPTH) begin
                exp_bits[model_count]  = pend_bits;
                exp_err[model_count]   = pend_err;
                exp_flags[model_count] = pend_flags;
                exp_count[model_count] = pend_count;
                model_count++;
            end
            for (int s = 0; s < WINDOW - 1; s++) begin
                hist_bits[s]  = hist_bits[s+1];
                hist_err[s]   = hist_err[s+1];
                hist_flags[s] = hist_flags[s+1];
            end
            hist_bits[WINDOW-1]  = sliced_bits_i;
            hist_err[WINDOW-1]   = est_error_i;
            hist_flags[WINDOW-1] = sd_flags_i;
            pend_trig  = expected_trigger(prbs_flags_i, mode_i);
            pend_count = lane_cnt_t'(count_flags(prbs_flags_i));
            pend_bits  = hist_bits;
            pend_err   = hist_err;
            pend_flags = hist_flags;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check(input string name, input logic [LANES*ERR_W-1:0] exp,
                         input logic [LANES*ERR_W-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
            $display("Test failed");
            $fatal(1, "stopping on first error");
        end
    endtask

    function automatic lane_vec_t random_flags(int density);
        case (density)
            0:       return '0;
            1:       return lane_vec_t'($urandom & $urandom & $urandom);
            2:       return lane_vec_t'($urandom & $urandom);
            default: return lane_vec_t'($urandom);
        endcase
    endfunction

    // Called on a falling edge, returns on the next one.
    task automatic drive_cycle(input lane_vec_t flags);
        prbs_flags_i  = flags;
        sliced_bits_i = lane_vec_t'($urandom);
        est_error_i   = {$urandom, $urandom, $urandom, $urandom};
        sd_flags_i    = flag_vec_t'({$urandom, $urandom});
        @(negedge clk);
    endtask

    task automatic drain();
        drive_cycle('0);
        drive_cycle('0);                         // Last trigger lands here.
    endtask

    task automatic pulse_clear();
        clear_i = 1'b1;
        drive_cycle('0);
        clear_i = 1'b0;
    endtask

    task automatic check_fill(input string name);
        check({name, " count"}, model_count, capture_count_o);
        check({name, " full"}, model_count == DEPTH, full_o);
    endtask

    task automatic read_all(input string name);
        lane_vec_t e_bits;
        err_vec_t  e_err;
        flag_vec_t e_flags;
        lane_cnt_t e_cnt;
        for (int a = 0; a < DEPTH; a++) begin
            for (int s = 0; s < 4; s++) begin
                rd_addr_i = cap_addr_t'(a);
                rd_slot_i = slot_t'(s);
                @(negedge clk);                  // One edge of read latency.
                e_bits  = '0;
                e_err   = '0;
                e_flags = '0;
                e_cnt   = '0;
                if (a < model_count) begin
                    e_cnt = exp_count[a];        // Count ignores the slot.
                    if (s < WINDOW) begin
                        e_bits  = exp_bits[a][s];
                        e_err   = exp_err[a][s];
                        e_flags = exp_flags[a][s];
                    end
                end
                check({name, " bits"}, e_bits, rd_bits_o);
                check({name, " err"}, e_err, rd_err_o);
                check({name, " flags"}, e_flags, rd_flags_o);
                check({name, " lane count"}, e_cnt, rd_count_o);
            end
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(60));
        clk           = 1'b0;
        rstb          = 1'b0;
        prbs_flags_i  = '0;
        sliced_bits_i = '0;
        est_error_i   = '0;
        sd_flags_i    = '0;
        mode_i        = '0;
        clear_i       = 1'b0;
        rd_addr_i     = '0;
        rd_slot_i     = '0;
        cycles        = 0;
        errors        = 0;
        repeat (4) @(negedge clk);
        rstb = 1'b1;

        check_fill("reset");
        read_all("reset");

        for (int m = 0; m < 4; m++) begin
            pulse_clear();
            mode_i = mode_t'(m);
            for (int c = 0; c < RUN_CYCLES; c++) begin
                drive_cycle(random_flags($urandom_range(0, 3)));
            end
            drain();
            check_fill($sformatf("mode%0d", m));
            read_all($sformatf("mode%0d window", m));
        end

        pulse_clear();                           // Back to back in mode 0.
        mode_i = '0;
        repeat (6) drive_cycle('1);
        drain();
        check_fill("back to back");
        read_all("back to back");

        pulse_clear();                           // Fill, then overflow.
        repeat (DEPTH + 2) drive_cycle(random_flags(3) | lane_vec_t'(1));
        drain();
        check_fill("full");
        repeat (6) drive_cycle('1);
        drain();
        check_fill("drop");
        read_all("drop");

        pulse_clear();
        check_fill("clear");
        read_all("clear");
        drive_cycle('1);
        drain();
        check_fill("after clear");
        read_all("after clear");

        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : error_tracker_tb

//--- vlog.f
verilog/error_tracker_pkg.sv
verilog/trigger_detector.sv
verilog/sample_history.sv
verilog/capture_memory.sv
verilog/error_tracker.sv
dv/error_tracker_tb.sv

//--- Bender.yml
package:
  name: error_tracker

sources:
  # Package first, then the blocks, then the top level.
  - target: any(rtl, test)
    files:
      - verilog/error_tracker_pkg.sv
      - verilog/trigger_detector.sv
      - verilog/sample_history.sv
      - verilog/capture_memory.sv
      - verilog/error_tracker.sv

  # Testbench, top module error_tracker_tb.
  - target: test
    files:
      - dv/error_tracker_tb.sv
